//--- pipe_backend.f
cpu_types_pkg.sv
datapath_mux_pkg.sv
ex_mem_reg_if.sv
ex_stage.sv
ex_mem_reg.sv
mem_stage.sv
pipe_backend.sv
backend_props.sv
backend_checker.sv
tb_pipe_backend.sv

//--- run.sh
#!/usr/bin/env bash
# build the back end testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_pipe_backend \
	-f pipe_backend.f

./obj_dir/Vtb_pipe_backend | tee sim.log

if grep -qx "Everything OK" sim.log; then
	exit 0
else
	exit 1
fi

//--- tb_pipe_backend.sv
/* pipeline back end testbench: clock, reset, stimulus, reference model,
   watchdog and summary */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_backend;

	localparam int RESET_CYCLES = 16;
	localparam int IDLE_STEPS = 4;
	localparam int ALU_STEPS = 24;
	localparam int MEM_PAIRS = 4;
	localparam int BEQ_STEPS = 6;
	// idle, alu, store/load pairs, cold loads, beq, flush and stall, halt, flushed beq and lw
	localparam int TOTAL_STEPS = IDLE_STEPS + ALU_STEPS + 2 * MEM_PAIRS + 2 + BEQ_STEPS
		+ 7 + 4 + 2;
	localparam int MARGIN_CYCLES = 20;

	typedef struct packed {
		logic                    wen;
		cpu_types_pkg::regbits_t addr;
		cpu_types_pkg::word_t    data;
		logic                    btaken;
		cpu_types_pkg::word_t    btarget;
		logic                    halt;
	} wb_expect_t;

	logic CLK;
	logic nRST;
	logic enable;
	logic flush;
	cpu_types_pkg::opcode_t id_opcode;
	cpu_types_pkg::funct_t id_funct;
	cpu_types_pkg::word_t id_rdat1, id_rdat2, id_npc;
	logic [15:0] id_imm16;
	cpu_types_pkg::regbits_t id_rs, id_rt, id_rd;
	logic wb_wen, halt, branch_taken;
	cpu_types_pkg::regbits_t wb_addr;
	cpu_types_pkg::word_t wb_data, branch_target;

	integer seed;
	int n_issued;
	cpu_types_pkg::word_t ram_model [cpu_types_pkg::DMEM_WORDS];
	// what EX/MEM should hold right now
	wb_expect_t slot;
	string slot_name;
	logic halt_seen;

	pipe_backend DUT (
		.CLK           (CLK),
		.nRST          (nRST),
		.enable        (enable),
		.flush         (flush),
		.id_opcode     (id_opcode),
		.id_funct      (id_funct),
		.id_rdat1      (id_rdat1),
		.id_rdat2      (id_rdat2),
		.id_imm16      (id_imm16),
		.id_rs         (id_rs),
		.id_rt         (id_rt),
		.id_rd         (id_rd),
		.id_npc        (id_npc),
		.wb_wen        (wb_wen),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.halt          (halt),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	backend_checker u_chk (
		.CLK           (CLK),
		.wb_wen        (wb_wen),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.halt          (halt),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	bind ex_mem_reg backend_props u_props (
		.CLK    (CLK),
		.nRST   (nRST),
		.enable (ex_mem_regif.enable),
		.flush  (ex_mem_regif.flush),
		.wen    (ex_mem_regif.WEN_ex_mem),
		.dren   (ex_mem_regif.dREN_ex_mem),
		.dwen   (ex_mem_regif.dWEN_ex_mem),
		.halt   (ex_mem_regif.halt_ex_mem),
		.branch (ex_mem_regif.branch_ex_mem),
		.result (ex_mem_regif.result_ex_mem),
		.rt     (ex_mem_regif.Rt_ex_mem),
		.rd     (ex_mem_regif.Rd_ex_mem)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic cpu_types_pkg::word_t rand_word();
		rand_word = $random(seed);
	endfunction

	// expected writeback of one instruction, straight from the ISA rules
	function automatic wb_expect_t predict_wb(
		input cpu_types_pkg::opcode_t  op,
		input cpu_types_pkg::funct_t   fn,
		input cpu_types_pkg::word_t    a,
		input cpu_types_pkg::word_t    b,
		input logic [15:0]             imm,
		input cpu_types_pkg::regbits_t rt,
		input cpu_types_pkg::regbits_t rd,
		input cpu_types_pkg::word_t    npc
	);
		wb_expect_t e;
		cpu_types_pkg::word_t se;
		cpu_types_pkg::word_t ea;
		e = '0;
		se = {{16{imm[15]}}, imm};
		ea = a + se;
		e.addr = rt;
		case (op)
			cpu_types_pkg::RTYPE: begin
				e.wen = 1'b1;
				e.addr = rd;
				case (fn)
					cpu_types_pkg::ADDU:  e.data = a + b;
					cpu_types_pkg::SUBU:  e.data = a - b;
					cpu_types_pkg::AND_F: e.data = a & b;
					cpu_types_pkg::OR_F:  e.data = a | b;
					cpu_types_pkg::XOR_F: e.data = a ^ b;
					cpu_types_pkg::SLT:   e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					cpu_types_pkg::SLL:   e.data = b << imm[10:6];
					default:              e.wen = 1'b0;
				endcase
			end
			cpu_types_pkg::ADDIU: begin
				e.wen = 1'b1;
				e.data = ea;
			end
			cpu_types_pkg::ORI: begin
				e.wen = 1'b1;
				e.data = a | {16'h0000, imm};
			end
			cpu_types_pkg::LUI: begin
				e.wen = 1'b1;
				e.data = {imm, 16'h0000};
			end
			// word index is byte address bits 7:2
			cpu_types_pkg::LW: begin
				e.wen = 1'b1;
				e.data = ram_model[ea[7:2]];
			end
			cpu_types_pkg::BEQ: begin
				e.btaken = (a == b);
				e.btarget = npc + {se[29:0], 2'b00};
			end
			cpu_types_pkg::HALT: e.halt = 1'b1;
			default: ;
		endcase
		return e;
	endfunction

	// one falling edge: drive the inputs, queue the outputs due after the next edge
	task automatic issue(
		input string                   name,
		input cpu_types_pkg::opcode_t  op,
		input cpu_types_pkg::funct_t   fn,
		input cpu_types_pkg::word_t    a,
		input cpu_types_pkg::word_t    b,
		input logic [15:0]             imm,
		input cpu_types_pkg::regbits_t rt,
		input cpu_types_pkg::regbits_t rd,
		input cpu_types_pkg::word_t    npc,
		input logic                    en,
		input logic                    fl
	);
		wb_expect_t out_e;
		string out_name;
		cpu_types_pkg::word_t ea;
		cpu_types_pkg::word_t r;
		r = rand_word();
		@(negedge CLK);
		enable = en;
		flush = fl;
		id_opcode = op;
		id_funct = fn;
		id_rdat1 = a;
		id_rdat2 = b;
		id_imm16 = imm;
		id_rs = r[4:0];
		id_rt = rt;
		id_rd = rd;
		id_npc = npc;
		if (en) begin
			out_e = slot;
			out_name = slot_name;
		end else begin
			out_e = '0;
			out_name = {"stall behind ", slot_name};
		end
		out_e.halt = out_e.halt | halt_seen;
		halt_seen = out_e.halt;
		u_chk.expect_out(out_name, out_e.wen, out_e.addr, out_e.data, out_e.btaken,
			out_e.btarget, out_e.halt);
		n_issued++;
		// EX/MEM after the edge
		if (en && !fl) begin
			slot = predict_wb(op, fn, a, b, imm, rt, rd, npc);
			slot_name = name;
			ea = a + {{16{imm[15]}}, imm};
			if (op == cpu_types_pkg::SW)
				ram_model[ea[7:2]] = b;
		end else if (fl) begin
			slot = '0;
			slot_name = {"flushed ", name};
		end
	endtask

	task automatic alu_random(input string tag, input int n);
		cpu_types_pkg::opcode_t op;
		cpu_types_pkg::funct_t fn;
		cpu_types_pkg::word_t sel, a, b, f, npc;
		op = cpu_types_pkg::RTYPE;
		fn = cpu_types_pkg::ADDU;
		sel = rand_word();
		a = rand_word();
		b = rand_word();
		f = rand_word();
		npc = rand_word();
		case (sel % 10)
			0: fn = cpu_types_pkg::ADDU;
			1: fn = cpu_types_pkg::SUBU;
			2: fn = cpu_types_pkg::AND_F;
			3: fn = cpu_types_pkg::OR_F;
			4: fn = cpu_types_pkg::XOR_F;
			5: fn = cpu_types_pkg::SLT;
			6: fn = cpu_types_pkg::SLL;
			7: op = cpu_types_pkg::ADDIU;
			8: op = cpu_types_pkg::ORI;
			default: op = cpu_types_pkg::LUI;
		endcase
		issue($sformatf("%s_%0d_%s", tag, n,
			(op == cpu_types_pkg::RTYPE) ? fn.name() : op.name()),
			op, fn, a, b, f[15:0], f[20:16], f[25:21], {npc[31:2], 2'b00}, 1'b1, 1'b0);
	endtask

	// store to a word in the lower half, load it back through another base
	task automatic store_load(input int n);
		cpu_types_pkg::word_t r, r2, data, addr, base1, base2;
		logic [15:0] off1, off2;
		r = rand_word();
		r2 = rand_word();
		data = rand_word();
		addr = {r[31:8], 1'b0, r[4:0], 2'b00};
		off1 = {{9{r2[6]}}, r2[6:0]};
		off2 = {{9{r2[14]}}, r2[14:8]};
		base1 = addr - {{16{off1[15]}}, off1};
		base2 = addr - {{16{off2[15]}}, off2};
		issue($sformatf("sw_%0d", n), cpu_types_pkg::SW, cpu_types_pkg::ADDU, base1, data,
			off1, r2[20:16], 5'd0, 32'h0000_0100, 1'b1, 1'b0);
		issue($sformatf("lw_%0d", n), cpu_types_pkg::LW, cpu_types_pkg::ADDU, base2, r,
			off2, r2[25:21], 5'd0, 32'h0000_0104, 1'b1, 1'b0);
	endtask

	// upper half of the RAM is never stored to by store_load
	task automatic cold_load(input string name, input cpu_types_pkg::word_t r);
		issue(name, cpu_types_pkg::LW, cpu_types_pkg::ADDU,
			{r[31:8], 1'b1, r[4:0], 2'b00}, r, 16'h0000, r[12:8], 5'd0,
			32'h0000_0200, 1'b1, 1'b0);
	endtask

	task automatic beq_check(input int n, input logic equal);
		cpu_types_pkg::word_t a, b, r;
		a = rand_word();
		r = rand_word();
		b = equal ? a : (a ^ {r[31:1], 1'b1});
		issue($sformatf("beq_%0d_%s", n, equal ? "equal" : "unequal"), cpu_types_pkg::BEQ,
			cpu_types_pkg::ADDU, a, b, r[15:0], r[20:16], 5'd0, {r[31:2], 2'b00},
			1'b1, 1'b0);
	endtask

	initial begin
		int i;
		cpu_types_pkg::word_t r;
		seed = 23267;
		n_issued = 0;
		halt_seen = 1'b0;
		slot = '0;
		slot_name = "reset bubble";
		for (i = 0; i < cpu_types_pkg::DMEM_WORDS; i++)
			ram_model[i] = '0;
		nRST = 1'b0;
		enable = 1'b0;
		flush = 1'b0;
		id_opcode = cpu_types_pkg::RTYPE;
		id_funct = cpu_types_pkg::ADDU;
		id_rdat1 = '0;
		id_rdat2 = '0;
		id_imm16 = '0;
		id_rs = '0;
		id_rt = '0;
		id_rd = '0;
		id_npc = '0;
		repeat (RESET_CYCLES) @(negedge CLK);
		nRST = 1'b1;

		// quiet after reset
		for (i = 0; i < IDLE_STEPS; i++)
			issue("idle", cpu_types_pkg::RTYPE, cpu_types_pkg::ADDU, '0, '0, '0, '0, '0, '0,
				1'b0, 1'b0);

		for (i = 0; i < ALU_STEPS; i++)
			alu_random("alu", i);

		for (i = 0; i < MEM_PAIRS; i++)
			store_load(i);
		cold_load("lw_unwritten_0", rand_word());
		cold_load("lw_unwritten_1", rand_word());

		for (i = 0; i < BEQ_STEPS; i++)
			beq_check(i, i[0]);

		// flush at presentation, then a stall with the instruction held
		r = rand_word();
		issue("flush_addiu", cpu_types_pkg::ADDIU, cpu_types_pkg::ADDU, r, r, r[15:0],
			5'd9, 5'd0, 32'h0000_0300, 1'b1, 1'b1);
		issue("flush_sw", cpu_types_pkg::SW, cpu_types_pkg::ADDU,
			{r[31:8], 1'b1, r[4:0], 2'b00}, ~r, 16'h0000, 5'd3, 5'd0, 32'h0000_0304,
			1'b1, 1'b1);
		cold_load("lw_after_flushed_sw", r);
		issue("stalled_addiu", cpu_types_pkg::ADDIU, cpu_types_pkg::ADDU, r, ~r, 16'h8001,
			5'd17, 5'd0, 32'h0000_030c, 1'b1, 1'b0);
		issue("ignored_in_stall", cpu_types_pkg::ORI, cpu_types_pkg::ADDU, ~r, r, 16'h1234,
			5'd4, 5'd0, 32'h0000_0310, 1'b0, 1'b0);
		issue("ignored_in_stall", cpu_types_pkg::LUI, cpu_types_pkg::ADDU, ~r, r, 16'h4321,
			5'd5, 5'd0, 32'h0000_0310, 1'b0, 1'b0);
		issue("after_stall_ori", cpu_types_pkg::ORI, cpu_types_pkg::ADDU, r, r, 16'h00f0,
			5'd21, 5'd0, 32'h0000_0310, 1'b1, 1'b0);

		// halt is sticky while the pipe keeps running
		issue("halt", cpu_types_pkg::HALT, cpu_types_pkg::ADDU, '0, '0, '0, '0, '0,
			32'h0000_0314, 1'b1, 1'b0);
		for (i = 0; i < 3; i++)
			alu_random("post_halt", i);

		// a taken branch and a load, both flushed at presentation
		issue("flush_beq", cpu_types_pkg::BEQ, cpu_types_pkg::ADDU, r, r, 16'h0004,
			5'd0, 5'd0, 32'h0000_0318, 1'b1, 1'b1);
		issue("flush_lw", cpu_types_pkg::LW, cpu_types_pkg::ADDU,
			{r[31:8], 1'b1, r[4:0], 2'b00}, r, 16'h0000, 5'd7, 5'd0, 32'h0000_031c,
			1'b1, 1'b1);

		repeat (2) @(negedge CLK);
		if (u_chk.pass_cnt + u_chk.fail_cnt != n_issued)
			$display("only %0d of %0d expected results were compared",
				u_chk.pass_cnt + u_chk.fail_cnt, n_issued);
		$display("tests: %0d passed, %0d failed", u_chk.pass_cnt, u_chk.fail_cnt);
		if (u_chk.fail_cnt == 0 && u_chk.pass_cnt == n_issued) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// one cycle per issued step plus reset and slack
	initial begin
		#((RESET_CYCLES + TOTAL_STEPS + MARGIN_CYCLES) * 100);
		$display("watchdog expired after %0d cycles, the run did not finish",
			RESET_CYCLES + TOTAL_STEPS + MARGIN_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- backend_checker.sv
/* checker: expected writeback and branch results per edge, compared against the DUT */
`timescale 1ns/1ps
`default_nettype none

module backend_checker (
	input logic                    CLK,
	input logic                    wb_wen,
	input cpu_types_pkg::regbits_t wb_addr,
	input cpu_types_pkg::word_t    wb_data,
	input logic                    halt,
	input logic                    branch_taken,
	input cpu_types_pkg::word_t    branch_target
);

	// {wen, addr, data, taken, target, halt}
	logic [71:0] exp_q [$];
	string name_q [$];

	logic [71:0] cur_exp;
	string cur_name;
	logic cur_valid = 1'b0;
	int pass_cnt = 0;
	int fail_cnt = 0;

	logic e_wen, e_bt, e_halt;
	cpu_types_pkg::regbits_t e_addr;
	cpu_types_pkg::word_t e_data, e_tgt;

	// called by the testbench on the falling edge before the edge it describes
	task automatic expect_out(
		input string                   name,
		input logic                    wen,
		input cpu_types_pkg::regbits_t addr,
		input cpu_types_pkg::word_t    data,
		input logic                    taken,
		input cpu_types_pkg::word_t    target,
		input logic                    hlt
	);
		name_q.push_back(name);
		exp_q.push_back({wen, addr, data, taken, target, hlt});
	endtask

	task automatic report_mismatch(
		input string                field,
		input cpu_types_pkg::word_t exp_v,
		input cpu_types_pkg::word_t act_v
	);
		$display("FAILED %s: %s expected 0x%h, actual 0x%h", cur_name, field, exp_v, act_v);
		fail_cnt++;
	endtask

	// pick up the expectation for the outputs after this edge
	always @(posedge CLK) begin
		if (name_q.size() > 0) begin
			cur_name = name_q.pop_front();
			cur_exp = exp_q.pop_front();
			cur_valid = 1'b1;
		end else begin
			cur_valid = 1'b0;
		end
	end

	// outputs are settled by the falling edge
	always @(negedge CLK) begin
		if (cur_valid) begin
			{e_wen, e_addr, e_data, e_bt, e_tgt, e_halt} = cur_exp;
			if (wb_wen !== e_wen)
				report_mismatch("wb_wen", {31'd0, e_wen}, {31'd0, wb_wen});
			else if (e_wen && wb_addr !== e_addr)
				report_mismatch("wb_addr", {27'd0, e_addr}, {27'd0, wb_addr});
			else if (e_wen && wb_data !== e_data)
				report_mismatch("wb_data", e_data, wb_data);
			else if (halt !== e_halt)
				report_mismatch("halt", {31'd0, e_halt}, {31'd0, halt});
			else if (branch_taken !== e_bt)
				report_mismatch("branch_taken", {31'd0, e_bt}, {31'd0, branch_taken});
			else if (e_bt && branch_target !== e_tgt)
				report_mismatch("branch_target", e_tgt, branch_target);
			else begin
				$display("PASS %s", cur_name);
				pass_cnt++;
			end
		end
	end

endmodule

`default_nettype wire

//--- backend_props.sv
/* concurrent assertions on the EX/MEM register flush and hold rules */
`timescale 1ns/1ps
`default_nettype none

module backend_props (
	input logic                    CLK,
	input logic                    nRST,
	input logic                    enable,
	input logic                    flush,
	input logic                    wen,
	input logic                    dren,
	input logic                    dwen,
	input logic                    halt,
	input logic                    branch,
	input cpu_types_pkg::word_t    result,
	input cpu_types_pkg::regbits_t rt,
	input cpu_types_pkg::regbits_t rd
);

	// flush wins over enable and leaves a bubble
	flush_clears_writes: assert property (@(posedge CLK) disable iff (!nRST)
		flush |=> (!wen && !dwen && !halt))
		else $error("flush left a register write, store or halt in EX/MEM");

	flush_clears_branch: assert property (@(posedge CLK) disable iff (!nRST)
		flush |=> (!branch && !dren))
		else $error("flush left a branch or load in EX/MEM");

	// stalled stage keeps its contents
	stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
		(!enable && !flush) |=> $stable({wen, dren, dwen, halt, branch, result, rt, rd}))
		else $error("EX/MEM changed while enable was low");

endmodule

`default_nettype wire

//--- pipe_backend.sv
/* pipeline back end top: execute, EX/MEM register, memory and writeback */
`timescale 1ns/1ps
`default_nettype none

module pipe_backend (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    enable,
	input  logic                    flush,
	input  cpu_types_pkg::opcode_t  id_opcode,
	input  cpu_types_pkg::funct_t   id_funct,
	input  cpu_types_pkg::word_t    id_rdat1,
	input  cpu_types_pkg::word_t    id_rdat2,
	input  logic [15:0]             id_imm16,
	input  cpu_types_pkg::regbits_t id_rs,
	input  cpu_types_pkg::regbits_t id_rt,
	input  cpu_types_pkg::regbits_t id_rd,
	input  cpu_types_pkg::word_t    id_npc,
	output logic                    wb_wen,
	output cpu_types_pkg::regbits_t wb_addr,
	output cpu_types_pkg::word_t    wb_data,
	output logic                    halt,
	output logic                    branch_taken,
	output cpu_types_pkg::word_t    branch_target
);

	ex_mem_reg_if exmif ();

	// stage control comes straight from outside
	assign exmif.enable = enable;
	assign exmif.flush = flush;

	ex_stage u_ex (
		.id_opcode (id_opcode),
		.id_funct  (id_funct),
		.id_rdat1  (id_rdat1),
		.id_rdat2  (id_rdat2),
		.id_imm16  (id_imm16),
		.id_rs     (id_rs),
		.id_rt     (id_rt),
		.id_rd     (id_rd),
		.id_npc    (id_npc),
		.exif      (exmif.ex)
	);

	ex_mem_reg u_ex_mem (
		.CLK          (CLK),
		.nRST         (nRST),
		.ex_mem_regif (exmif.regs)
	);

	mem_stage u_mem (
		.CLK           (CLK),
		.nRST          (nRST),
		.enable        (enable),
		.memif         (exmif.mem),
		.wb_wen        (wb_wen),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.halt          (halt),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

endmodule

`default_nettype wire

//--- mem_stage.sv
/* memory stage: data RAM, writeback and destination muxes, writeback register */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    enable,
	ex_mem_reg_if.mem               memif,
	output logic                    wb_wen,
	output cpu_types_pkg::regbits_t wb_addr,
	output cpu_types_pkg::word_t    wb_data,
	output logic                    halt,
	output logic                    branch_taken,
	output cpu_types_pkg::word_t    branch_target
);

	cpu_types_pkg::word_t dmem [cpu_types_pkg::DMEM_WORDS];
	logic [cpu_types_pkg::DMEM_ABITS-1:0] dmem_idx;
	cpu_types_pkg::word_t dmem_rdata;
	cpu_types_pkg::word_t wb_data_nxt;
	cpu_types_pkg::regbits_t wb_addr_nxt;

	// word index from the byte address
	assign dmem_idx = memif.result_ex_mem[cpu_types_pkg::DMEM_ABITS+1:2];
	assign dmem_rdata = memif.dREN_ex_mem ? dmem[dmem_idx] : '0;

	// RAM clears on reset so unwritten words read back as zero
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < cpu_types_pkg::DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (enable && memif.dWEN_ex_mem) begin
			dmem[dmem_idx] <= memif.data_store_ex_mem;
		end
	end

	assign wb_data_nxt = (memif.mem_to_reg_ex_mem == datapath_mux_pkg::SEL_MEMDATA) ?
		dmem_rdata : memif.result_ex_mem;
	assign wb_addr_nxt = (memif.reg_dest_ex_mem == datapath_mux_pkg::SEL_RD) ?
		memif.Rd_ex_mem : memif.Rt_ex_mem;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_wen <= 1'b0;
			wb_addr <= '0;
			wb_data <= '0;
			halt <= 1'b0;
			branch_taken <= 1'b0;
			branch_target <= '0;
		end else if (enable) begin
			wb_wen <= memif.WEN_ex_mem;
			wb_addr <= wb_addr_nxt;
			wb_data <= wb_data_nxt;
			halt <= halt | memif.halt_ex_mem;
			branch_taken <= memif.branch_ex_mem & memif.zero_ex_mem;
			branch_target <= memif.branch_addr_ex_mem;
		end else begin
			// stalled, nothing retires; halt stays sticky
			wb_wen <= 1'b0;
			branch_taken <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- ex_mem_reg.sv
/* EX/MEM pipeline register with enable and flush */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
	input logic            CLK,
	input logic            nRST,
	ex_mem_reg_if.regs     ex_mem_regif
);

	// flush wins over load, load wins over hold
	// reset state is the bubble
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ex_mem_regif.WEN_ex_mem <= 1'b0;
			ex_mem_regif.dREN_ex_mem <= 1'b0;
			ex_mem_regif.dWEN_ex_mem <= 1'b0;
			ex_mem_regif.halt_ex_mem <= 1'b0;
			ex_mem_regif.branch_ex_mem <= 1'b0;
			ex_mem_regif.zero_ex_mem <= 1'b0;
			ex_mem_regif.reg_dest_ex_mem <= datapath_mux_pkg::SEL_RD;
			ex_mem_regif.mem_to_reg_ex_mem <= datapath_mux_pkg::SEL_RESULT;
			ex_mem_regif.alu_op_ex_mem <= cpu_types_pkg::ALU_ADD;
			ex_mem_regif.result_ex_mem <= '0;
			ex_mem_regif.data_store_ex_mem <= '0;
			ex_mem_regif.branch_addr_ex_mem <= '0;
			ex_mem_regif.Rt_ex_mem <= '0;
			ex_mem_regif.Rd_ex_mem <= '0;
			ex_mem_regif.npc_ex_mem <= '0;
			ex_mem_regif.rdat1_ex_mem <= '0;
			ex_mem_regif.opcode_ex_mem <= cpu_types_pkg::RTYPE;
			ex_mem_regif.funct_ex_mem <= cpu_types_pkg::ADDU;
			ex_mem_regif.imm16_ex_mem <= '0;
			ex_mem_regif.Rs_ex_mem <= '0;
		end else if (ex_mem_regif.enable && !ex_mem_regif.flush) begin
			ex_mem_regif.WEN_ex_mem <= ex_mem_regif.WEN;
			ex_mem_regif.dREN_ex_mem <= ex_mem_regif.dREN;
			ex_mem_regif.dWEN_ex_mem <= ex_mem_regif.dWEN;
			ex_mem_regif.halt_ex_mem <= ex_mem_regif.halt;
			ex_mem_regif.branch_ex_mem <= ex_mem_regif.branch;
			ex_mem_regif.zero_ex_mem <= ex_mem_regif.zero;
			ex_mem_regif.reg_dest_ex_mem <= ex_mem_regif.reg_dest;
			ex_mem_regif.mem_to_reg_ex_mem <= ex_mem_regif.mem_to_reg;
			ex_mem_regif.alu_op_ex_mem <= ex_mem_regif.alu_op;
			ex_mem_regif.result_ex_mem <= ex_mem_regif.result;
			ex_mem_regif.data_store_ex_mem <= ex_mem_regif.data_store;
			ex_mem_regif.branch_addr_ex_mem <= ex_mem_regif.branch_addr;
			ex_mem_regif.Rt_ex_mem <= ex_mem_regif.Rt;
			ex_mem_regif.Rd_ex_mem <= ex_mem_regif.Rd;
			// tracker
			ex_mem_regif.npc_ex_mem <= ex_mem_regif.npc;
			ex_mem_regif.rdat1_ex_mem <= ex_mem_regif.rdat1;
			ex_mem_regif.opcode_ex_mem <= ex_mem_regif.opcode;
			ex_mem_regif.funct_ex_mem <= ex_mem_regif.funct;
			ex_mem_regif.imm16_ex_mem <= ex_mem_regif.imm16;
			ex_mem_regif.Rs_ex_mem <= ex_mem_regif.Rs;
		end else if (ex_mem_regif.flush) begin
			// bubble, an r-type ADDU that writes nothing
			ex_mem_regif.WEN_ex_mem <= 1'b0;
			ex_mem_regif.dREN_ex_mem <= 1'b0;
			ex_mem_regif.dWEN_ex_mem <= 1'b0;
			ex_mem_regif.halt_ex_mem <= 1'b0;
			ex_mem_regif.branch_ex_mem <= 1'b0;
			ex_mem_regif.zero_ex_mem <= 1'b0;
			ex_mem_regif.reg_dest_ex_mem <= datapath_mux_pkg::SEL_RD;
			ex_mem_regif.mem_to_reg_ex_mem <= datapath_mux_pkg::SEL_RESULT;
			ex_mem_regif.alu_op_ex_mem <= cpu_types_pkg::ALU_ADD;
			ex_mem_regif.result_ex_mem <= '0;
			ex_mem_regif.data_store_ex_mem <= '0;
			ex_mem_regif.branch_addr_ex_mem <= '0;
			ex_mem_regif.Rt_ex_mem <= '0;
			ex_mem_regif.Rd_ex_mem <= '0;
			ex_mem_regif.npc_ex_mem <= '0;
			ex_mem_regif.rdat1_ex_mem <= '0;
			ex_mem_regif.opcode_ex_mem <= cpu_types_pkg::RTYPE;
			ex_mem_regif.funct_ex_mem <= cpu_types_pkg::ADDU;
			ex_mem_regif.imm16_ex_mem <= '0;
			ex_mem_regif.Rs_ex_mem <= '0;
		end
	end

endmodule

`default_nettype wire

//--- ex_stage.sv
/* execute stage: control decode, ALU, zero flag, branch target */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  cpu_types_pkg::opcode_t  id_opcode,
	input  cpu_types_pkg::funct_t   id_funct,
	input  cpu_types_pkg::word_t    id_rdat1,
	input  cpu_types_pkg::word_t    id_rdat2,
	input  logic [15:0]             id_imm16,
	input  cpu_types_pkg::regbits_t id_rs,
	input  cpu_types_pkg::regbits_t id_rt,
	input  cpu_types_pkg::regbits_t id_rd,
	input  cpu_types_pkg::word_t    id_npc,
	ex_mem_reg_if.ex                exif
);

	cpu_types_pkg::word_t imm_sext;
	cpu_types_pkg::word_t imm_zext;
	cpu_types_pkg::word_t alu_b;
	cpu_types_pkg::aluop_t alu_op;
	logic [4:0] shamt;

	assign imm_sext = {{16{id_imm16[15]}}, id_imm16};
	assign imm_zext = {16'h0000, id_imm16};
	// shamt sits in bits 10:6 of the r-type word
	assign shamt = id_imm16[10:6];

	always_comb begin
		exif.WEN = 1'b0;
		exif.dREN = 1'b0;
		exif.dWEN = 1'b0;
		exif.halt = 1'b0;
		exif.branch = 1'b0;
		exif.reg_dest = datapath_mux_pkg::SEL_RT;
		exif.mem_to_reg = datapath_mux_pkg::SEL_RESULT;
		alu_op = cpu_types_pkg::ALU_ADD;
		alu_b = imm_sext;
		case (id_opcode)
			cpu_types_pkg::RTYPE: begin
				exif.reg_dest = datapath_mux_pkg::SEL_RD;
				exif.WEN = 1'b1;
				alu_b = id_rdat2;
				case (id_funct)
					cpu_types_pkg::ADDU:  alu_op = cpu_types_pkg::ALU_ADD;
					cpu_types_pkg::SUBU:  alu_op = cpu_types_pkg::ALU_SUB;
					cpu_types_pkg::AND_F: alu_op = cpu_types_pkg::ALU_AND;
					cpu_types_pkg::OR_F:  alu_op = cpu_types_pkg::ALU_OR;
					cpu_types_pkg::XOR_F: alu_op = cpu_types_pkg::ALU_XOR;
					cpu_types_pkg::SLT:   alu_op = cpu_types_pkg::ALU_SLT;
					cpu_types_pkg::SLL:   alu_op = cpu_types_pkg::ALU_SLL;
					default:              exif.WEN = 1'b0;
				endcase
			end
			cpu_types_pkg::ADDIU: exif.WEN = 1'b1;
			cpu_types_pkg::ORI: begin
				exif.WEN = 1'b1;
				alu_op = cpu_types_pkg::ALU_OR;
				alu_b = imm_zext;
			end
			cpu_types_pkg::LUI: begin
				exif.WEN = 1'b1;
				alu_op = cpu_types_pkg::ALU_LUI;
			end
			cpu_types_pkg::LW: begin
				exif.WEN = 1'b1;
				exif.dREN = 1'b1;
				exif.mem_to_reg = datapath_mux_pkg::SEL_MEMDATA;
			end
			cpu_types_pkg::SW: exif.dWEN = 1'b1;
			cpu_types_pkg::BEQ: begin
				exif.branch = 1'b1;
				alu_op = cpu_types_pkg::ALU_SUB;
				alu_b = id_rdat2;
			end
			cpu_types_pkg::HALT: exif.halt = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		case (alu_op)
			cpu_types_pkg::ALU_ADD: exif.result = id_rdat1 + alu_b;
			cpu_types_pkg::ALU_SUB: exif.result = id_rdat1 - alu_b;
			cpu_types_pkg::ALU_AND: exif.result = id_rdat1 & alu_b;
			cpu_types_pkg::ALU_OR:  exif.result = id_rdat1 | alu_b;
			cpu_types_pkg::ALU_XOR: exif.result = id_rdat1 ^ alu_b;
			cpu_types_pkg::ALU_SLT: exif.result = {31'd0, $signed(id_rdat1) < $signed(alu_b)};
			cpu_types_pkg::ALU_SLL: exif.result = alu_b << shamt;
			cpu_types_pkg::ALU_LUI: exif.result = {id_imm16, 16'h0000};
			default:                exif.result = '0;
		endcase
	end

	// for BEQ the subtract is zero exactly when the operands match
	assign exif.zero = (exif.result == '0);
	assign exif.branch_addr = id_npc + (imm_sext << 2);
	assign exif.alu_op = alu_op;
	assign exif.data_store = id_rdat2;
	assign exif.Rt = id_rt;
	assign exif.Rd = id_rd;

	// tracker
	assign exif.npc = id_npc;
	assign exif.rdat1 = id_rdat1;
	assign exif.opcode = id_opcode;
	assign exif.funct = id_funct;
	assign exif.imm16 = id_imm16;
	assign exif.Rs = id_rs;

endmodule

`default_nettype wire

//--- ex_mem_reg_if.sv
/* EX/MEM register interface with ex, regs and mem modports */
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_reg_if;

	// stage control, driven from the top level
	logic enable;
	logic flush;

	// execute side
	logic WEN, dREN, dWEN, halt, branch, zero;
	datapath_mux_pkg::reg_dest_sel_t reg_dest;
	datapath_mux_pkg::mem_to_reg_sel_t mem_to_reg;
	cpu_types_pkg::aluop_t alu_op;
	cpu_types_pkg::word_t result, data_store, branch_addr;
	cpu_types_pkg::regbits_t Rt, Rd;

	// tracker fields
	cpu_types_pkg::word_t npc, rdat1;
	cpu_types_pkg::opcode_t opcode;
	cpu_types_pkg::funct_t funct;
	logic [15:0] imm16;
	cpu_types_pkg::regbits_t Rs;

	// registered copies
	logic WEN_ex_mem, dREN_ex_mem, dWEN_ex_mem, halt_ex_mem, branch_ex_mem, zero_ex_mem;
	datapath_mux_pkg::reg_dest_sel_t reg_dest_ex_mem;
	datapath_mux_pkg::mem_to_reg_sel_t mem_to_reg_ex_mem;
	cpu_types_pkg::aluop_t alu_op_ex_mem;
	cpu_types_pkg::word_t result_ex_mem, data_store_ex_mem, branch_addr_ex_mem;
	cpu_types_pkg::regbits_t Rt_ex_mem, Rd_ex_mem;
	cpu_types_pkg::word_t npc_ex_mem, rdat1_ex_mem;
	cpu_types_pkg::opcode_t opcode_ex_mem;
	cpu_types_pkg::funct_t funct_ex_mem;
	logic [15:0] imm16_ex_mem;
	cpu_types_pkg::regbits_t Rs_ex_mem;

	modport ex (
		output WEN, dREN, dWEN, halt, branch, zero, reg_dest, mem_to_reg, alu_op,
		output result, data_store, branch_addr, Rt, Rd,
		output npc, rdat1, opcode, funct, imm16, Rs
	);

	modport regs (
		input enable, flush,
		input WEN, dREN, dWEN, halt, branch, zero, reg_dest, mem_to_reg, alu_op,
		input result, data_store, branch_addr, Rt, Rd,
		input npc, rdat1, opcode, funct, imm16, Rs,
		output WEN_ex_mem, dREN_ex_mem, dWEN_ex_mem, halt_ex_mem, branch_ex_mem, zero_ex_mem,
		output reg_dest_ex_mem, mem_to_reg_ex_mem, alu_op_ex_mem,
		output result_ex_mem, data_store_ex_mem, branch_addr_ex_mem, Rt_ex_mem, Rd_ex_mem,
		output npc_ex_mem, rdat1_ex_mem, opcode_ex_mem, funct_ex_mem, imm16_ex_mem, Rs_ex_mem
	);

	modport mem (
		input WEN_ex_mem, dREN_ex_mem, dWEN_ex_mem, halt_ex_mem, branch_ex_mem, zero_ex_mem,
		input reg_dest_ex_mem, mem_to_reg_ex_mem, alu_op_ex_mem,
		input result_ex_mem, data_store_ex_mem, branch_addr_ex_mem, Rt_ex_mem, Rd_ex_mem,
		input npc_ex_mem, rdat1_ex_mem, opcode_ex_mem, funct_ex_mem, imm16_ex_mem, Rs_ex_mem
	);

endinterface

`default_nettype wire

//--- datapath_mux_pkg.sv
/* destination register and writeback source mux selects */
`default_nettype none

package datapath_mux_pkg;

	// which instruction field names the destination register
	typedef enum logic {
		SEL_RD,
		SEL_RT
	} reg_dest_sel_t;

	// writeback value source
	typedef enum logic {
		SEL_RESULT,
		SEL_MEMDATA
	} mem_to_reg_sel_t;

endpackage

`default_nettype wire

//--- cpu_types_pkg.sv
/* word and register-number types, opcode, funct and ALU operation enums,
   data RAM size */
`default_nettype none

package cpu_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regbits_t;

	// primary opcodes
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		BEQ   = 6'h04,
		ADDIU = 6'h09,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function field
	typedef enum logic [5:0] {
		SLL   = 6'h00,
		ADDU  = 6'h21,
		SUBU  = 6'h23,
		AND_F = 6'h24,
		OR_F  = 6'h25,
		XOR_F = 6'h26,
		SLT   = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluop_t;

	// data RAM geometry
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_ABITS = 6;

endpackage

`default_nettype wire
